// File: rtl/bus_ifs.sv
/* Bus target interfaces */

`timescale 1ns/10ps
`default_nettype none

// Main memory port, with byte mask
interface mem_if
    import snowflake_pkg::*;
(
    input logic clk,
    input logic rstz
);

    addr_t addr;
    word_t wr_data;
    logic  en;
    logic  wr_en;
    mask_t wr_mask;
    word_t rd_data;

    modport master (
        output addr, wr_data, en, wr_en, wr_mask,
        input  rd_data
    );

    modport target (
        input  clk, rstz,
        input  addr, wr_data, en, wr_en, wr_mask,
        output rd_data
    );

endinterface

// System register port, full-word writes only
interface sys_if
    import snowflake_pkg::*;
(
    input logic clk,
    input logic rstz
);

    addr_t addr;
    word_t wr_data;
    logic  en;
    logic  wr_en;
    word_t rd_data;

    modport master (
        output addr, wr_data, en, wr_en,
        input  rd_data
    );

    modport target (
        input  clk, rstz,
        input  addr, wr_data, en, wr_en,
        output rd_data
    );

endinterface

`default_nettype wire

// File: rtl/main_memory.sv
/* Word-organised main memory */

`timescale 1ns/10ps
`default_nettype none

module main_memory
    import snowflake_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    mem_if.target mem
);

    // Word index width, byte offset bits 1:0 dropped
    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t             ram [MEM_WORDS];
    logic  [IDX_W-1:0] word_idx;
    logic              wr_cycle;

    // ====================
    // Decode
    // ====================

    // Upper address bits ignored so accesses wrap inside the array
    assign word_idx = mem.addr[IDX_W+1:2];
    assign wr_cycle = mem.en && mem.wr_en;

    // ====================
    // Write path
    // ====================

    // Each byte lane follows its own mask bit
    always_ff @(posedge mem.clk) begin
        if (wr_cycle) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.wr_mask[b]) begin
                    ram[word_idx][8*b +: 8] <= mem.wr_data[8*b +: 8];
                end
            end
        end
    end

    // ====================
    // Read path
    // ====================

    // Registered read, old contents on a same-edge write
    always_ff @(posedge mem.clk) begin
        if (!mem.rstz) begin
            mem.rd_data <= '0;
        end
        else if (mem.en) begin
            mem.rd_data <= ram[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/snowflake_pkg.sv
/* Snowflake shared types */

`default_nettype none

package snowflake_pkg;

    // ====================
    // Bus vector types
    // ====================

    // One data word on either core port or target bus
    typedef logic [31:0] word_t;

    // Byte address as issued by the core
    typedef logic [31:0] addr_t;

    // Bit n enables byte n of a word
    typedef logic [3:0] mask_t;

    // LED port value
    typedef logic [7:0] led_t;

    // ====================
    // System space
    // ====================

    // Register count in one 256-byte system region
    localparam int SYS_WORDS = 64;

endpackage

`default_nettype wire

// File: rtl/snowflake_soc.sv
/* Snowflake bus fabric top */

`timescale 1ns/10ps
`default_nettype none

module snowflake_soc
    import snowflake_pkg::*;
#(
    parameter logic [3:0] SYSTEM_ID = 4'h0,
    parameter int         MEM_WORDS = 1024
) (
    input  logic  clk,
    input  logic  rstz,
    // Instruction port
    input  addr_t instr_addr,
    input  logic  instr_req,
    output word_t instr_data,
    output logic  instr_ack,
    // Data port
    input  addr_t data_addr,
    input  word_t data_wr_data,
    input  mask_t data_wr_mask,
    input  logic  data_wr_en,
    input  logic  data_req,
    output word_t data_rd_data,
    output logic  data_ack,
    // Board outputs
    output led_t  leds
);

    // ====================
    // Target buses
    // ====================

    mem_if mem_bus (
        .clk  (clk),
        .rstz (rstz)
    );

    sys_if sys_bus (
        .clk  (clk),
        .rstz (rstz)
    );

    // ====================
    // Bus
    // ====================

    snowflake_system_bus #(
        .SYSTEM_ID (SYSTEM_ID)
    ) u_bus (
        .clk          (clk),
        .rstz         (rstz),
        .instr_addr   (instr_addr),
        .instr_req    (instr_req),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .data_addr    (data_addr),
        .data_wr_data (data_wr_data),
        .data_wr_mask (data_wr_mask),
        .data_wr_en   (data_wr_en),
        .data_req     (data_req),
        .data_rd_data (data_rd_data),
        .data_ack     (data_ack),
        .mem          (mem_bus.master),
        .sys          (sys_bus.master)
    );

    // ====================
    // Targets
    // ====================

    main_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .mem (mem_bus.target)
    );

    system_regs u_sys (
        .sys  (sys_bus.target),
        .leds (leds)
    );

endmodule

`default_nettype wire

// File: rtl/snowflake_system_bus.sv
/* Snowflake system bus */

`timescale 1ns/10ps
`default_nettype none

module snowflake_system_bus
    import snowflake_pkg::*;
#(
    parameter logic [3:0] SYSTEM_ID = 4'h0
) (
    input  logic  clk,
    input  logic  rstz,
    // Instruction port
    input  addr_t instr_addr,
    input  logic  instr_req,
    output word_t instr_data,
    output logic  instr_ack,
    // Data port
    input  addr_t data_addr,
    input  word_t data_wr_data,
    input  mask_t data_wr_mask,
    input  logic  data_wr_en,
    input  logic  data_req,
    output word_t data_rd_data,
    output logic  data_ack,
    // Targets
    mem_if.master mem,
    sys_if.master sys
);

    logic       is_system;
    logic [3:0] region;
    logic       mem_data_req;
    logic       sys_data_req;
    logic       instr_grant;

    // Grant flags, one per possible acknowledge source
    logic       instr_grant_q;
    logic       mem_data_grant_q;
    logic       sys_data_grant_q;

    // ====================
    // Address decode
    // ====================

    // Bit 12 splits memory from system space
    assign is_system = data_addr[12];
    assign region    = data_addr[11:8];

    assign mem_data_req = data_req && !is_system;
    // Other system regions fall through and are never acknowledged
    assign sys_data_req = data_req && is_system && (region == SYSTEM_ID);

    // Data wins the memory port, instruction waits
    assign instr_grant = instr_req && !mem_data_req;

    // ====================
    // Main memory side
    // ====================

    always_comb begin
        mem.en      = instr_req || mem_data_req;
        mem.wr_en   = mem_data_req && data_wr_en;
        mem.addr    = mem_data_req ? data_addr : instr_addr;
        mem.wr_data = data_wr_data;
        mem.wr_mask = data_wr_mask;
    end

    // ====================
    // System side
    // ====================

    always_comb begin
        sys.en      = sys_data_req;
        sys.wr_en   = sys_data_req && data_wr_en;
        sys.addr    = data_addr;
        sys.wr_data = data_wr_data;
    end

    // ====================
    // Grants
    // ====================

    always_ff @(posedge clk) begin
        if (!rstz) begin
            instr_grant_q    <= 1'b0;
            mem_data_grant_q <= 1'b0;
            sys_data_grant_q <= 1'b0;
        end
        else begin
            instr_grant_q    <= instr_grant;
            mem_data_grant_q <= mem_data_req;
            sys_data_grant_q <= sys_data_req;
        end
    end

    // ====================
    // Responses
    // ====================

    // Instructions only ever come from memory
    assign instr_data = mem.rd_data;
    assign instr_ack  = instr_grant_q;

    // At most one data grant is set in any cycle
    always_comb begin
        data_ack     = mem_data_grant_q || sys_data_grant_q;
        data_rd_data = sys_data_grant_q ? sys.rd_data : mem.rd_data;
    end

endmodule

`default_nettype wire

// File: rtl/system_regs.sv
/* System register block */

`timescale 1ns/10ps
`default_nettype none

module system_regs
    import snowflake_pkg::*;
(
    sys_if.target sys,
    output led_t  leds
);

    localparam int IDX_W = $clog2(SYS_WORDS);

    word_t             regs [SYS_WORDS];
    logic  [IDX_W-1:0] reg_idx;
    logic              wr_cycle;

    // ====================
    // Decode
    // ====================

    // Region is 256 bytes, so bits 7:2 pick the word
    assign reg_idx  = sys.addr[IDX_W+1:2];
    assign wr_cycle = sys.en && sys.wr_en;

    // ====================
    // Register file
    // ====================

    // Whole-word writes, no byte mask on this port
    always_ff @(posedge sys.clk) begin
        if (!sys.rstz) begin
            for (int i = 0; i < SYS_WORDS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wr_cycle) begin
            regs[reg_idx] <= sys.wr_data;
        end
    end

    // ====================
    // Read path
    // ====================

    // Same timing as main memory, so the bus sees both alike
    always_ff @(posedge sys.clk) begin
        if (!sys.rstz) begin
            sys.rd_data <= '0;
        end
        else if (sys.en) begin
            sys.rd_data <= regs[reg_idx];
        end
    end

    // ====================
    // LED port
    // ====================

    // Low byte of word 0
    assign leds = regs[0][7:0];

endmodule

`default_nettype wire

// File: sources.f
rtl/snowflake_pkg.sv
rtl/bus_ifs.sv
rtl/main_memory.sv
rtl/system_regs.sv
rtl/snowflake_system_bus.sv
rtl/snowflake_soc.sv
tests/snowflake_assert.sv
tests/tb_snowflake_soc.sv

// File: tests/snowflake_assert.sv
/* Bus handshake assertions */

`timescale 1ns/10ps
`default_nettype none

module snowflake_assert
    import snowflake_pkg::*;
#(
    parameter logic [3:0] SYSTEM_ID = 4'h0
) (
    input logic  clk,
    input logic  rstz,
    input logic  instr_req,
    input logic  data_req,
    input addr_t data_addr,
    input logic  instr_ack,
    input logic  data_ack
);

    int   violations = 0;
    logic mem_data_req;
    logic decoded_data_req;

    assign mem_data_req     = data_req && !data_addr[12];
    assign decoded_data_req = mem_data_req
                              || (data_req && data_addr[12] && data_addr[11:8] == SYSTEM_ID);

    a_instr_ack_has_req: assert property (@(posedge clk) disable iff (!rstz)
        instr_ack |-> $past(instr_req))
        else begin violations++; $error("instr_ack without a request"); end

    a_data_ack_has_req: assert property (@(posedge clk) disable iff (!rstz)
        data_ack |-> $past(decoded_data_req))
        else begin violations++; $error("data_ack without a decoded request"); end

    // Memory data request owns the memory port
    a_instr_waits: assert property (@(posedge clk) disable iff (!rstz)
        $past(mem_data_req) |-> !instr_ack)
        else begin violations++; $error("instr_ack after a memory data request"); end

    a_acks_clear_after_reset: assert property (@(posedge clk)
        !rstz |=> (!instr_ack && !data_ack))
        else begin violations++; $error("acknowledge high after reset"); end

endmodule

bind snowflake_system_bus snowflake_assert #(.SYSTEM_ID(SYSTEM_ID)) u_assert (
    .clk       (clk),
    .rstz      (rstz),
    .instr_req (instr_req),
    .data_req  (data_req),
    .data_addr (data_addr),
    .instr_ack (instr_ack),
    .data_ack  (data_ack)
);

`default_nettype wire

// File: tests/tb_snowflake_soc.sv
/* Snowflake bus fabric testbench */

`timescale 1ns/10ps
`default_nettype none

module tb_snowflake_soc
    import snowflake_pkg::*;
();

    localparam logic [3:0] SYSTEM_ID     = 4'h0;
    localparam int         MEM_WORDS     = 1024;
    localparam int         CLK_NS        = 20;
    localparam int         RAND_ACCESSES = 300;
    // Reset, full words, masks, priority, system regs, other region, random
    localparam int TEST_CYCLES   = 11 + 49 + 49 + 4 + 130 + 4 + 32 + RAND_ACCESSES + 1;
    localparam int MARGIN_CYCLES = 200;

    logic  clk;
    logic  rstz;
    addr_t instr_addr;
    logic  instr_req;
    word_t instr_data;
    logic  instr_ack;
    addr_t data_addr;
    word_t data_wr_data;
    mask_t data_wr_mask;
    logic  data_wr_en;
    logic  data_req;
    word_t data_rd_data;
    logic  data_ack;
    led_t  leds;

    // Reference model of both targets
    word_t ref_mem [MEM_WORDS];
    word_t ref_sys [SYS_WORDS];

    snowflake_soc #(
        .SYSTEM_ID (SYSTEM_ID),
        .MEM_WORDS (MEM_WORDS)
    ) uut (
        .clk          (clk),
        .rstz         (rstz),
        .instr_addr   (instr_addr),
        .instr_req    (instr_req),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .data_addr    (data_addr),
        .data_wr_data (data_wr_data),
        .data_wr_mask (data_wr_mask),
        .data_wr_en   (data_wr_en),
        .data_req     (data_req),
        .data_rd_data (data_rd_data),
        .data_ack     (data_ack),
        .leds         (leds)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_NS);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    // ====================
    // Model helpers
    // ====================

    // Addresses wrap inside each target
    function automatic int mem_index(input addr_t a);
        return (a >> 2) % MEM_WORDS;
    endfunction

    function automatic int sys_index(input addr_t a);
        return (a >> 2) % SYS_WORDS;
    endfunction

    function automatic addr_t sys_addr(input int idx);
        return 32'h1000 | (addr_t'(SYSTEM_ID) << 8) | (addr_t'(idx) << 2);
    endfunction

    // Old word with the masked bytes replaced
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input mask_t m);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopping on first mismatch");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s returned %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_leds(input led_t exp);
        if (leds !== exp) begin
            report_mismatch($sformatf("leds are %h, expected %h", leds, exp));
        end
    endtask

    task automatic check_ack(input logic exp, input string port);
        logic got;
        got = (port == "instr") ? instr_ack : data_ack;
        if (got !== exp) begin
            report_mismatch($sformatf("%s ack is %b, expected %b", port, got, exp));
        end
    endtask

    // ====================
    // Core-side accesses
    // ====================

    // Each access starts and ends on a falling edge
    task automatic data_access(input addr_t a, input logic we, input word_t wd,
                               input mask_t m, input logic check_old);
        word_t expect_rd;
        int    idx;
        data_addr    = a;
        data_wr_en   = we;
        data_wr_data = wd;
        data_wr_mask = m;
        data_req     = 1'b1;
        @(negedge clk);
        check_ack(1'b1, "data");
        check_ack(1'b0, "instr");
        if (a[12]) begin
            idx       = sys_index(a);
            expect_rd = ref_sys[idx];
            if (we) begin
                ref_sys[idx] = wd;
            end
        end
        else begin
            idx       = mem_index(a);
            expect_rd = ref_mem[idx];
            if (we) begin
                ref_mem[idx] = merge_bytes(ref_mem[idx], wd, m);
            end
        end
        // Writes also return the old word
        if (check_old) begin
            check_word(data_rd_data, expect_rd, "data port");
        end
        data_req   = 1'b0;
        data_wr_en = 1'b0;
    endtask

    task automatic fetch(input addr_t a);
        instr_addr = a;
        instr_req  = 1'b1;
        @(negedge clk);
        check_ack(1'b1, "instr");
        check_ack(1'b0, "data");
        check_word(instr_data, ref_mem[mem_index(a)], "instruction fetch");
        instr_req = 1'b0;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        check_ack(1'b0, "instr");
        check_ack(1'b0, "data");
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic test_full_words();
        for (int i = 0; i < 16; i++) begin
            data_access(addr_t'(i * 64), 1'b1, word_t'($urandom), 4'hf, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            fetch(addr_t'(i * 64));
            data_access(addr_t'(i * 64), 1'b0, '0, 4'h0, 1'b1);
        end
        idle_cycle();
    endtask

    task automatic test_byte_masks();
        addr_t a;
        for (int m = 0; m < 16; m++) begin
            a = 32'h800 + addr_t'(m * 4);
            data_access(a, 1'b1, word_t'($urandom), 4'hf, 1'b0);
            data_access(a, 1'b1, word_t'($urandom), mask_t'(m), 1'b1);
            data_access(a, 1'b0, '0, 4'h0, 1'b1);
        end
        idle_cycle();
    endtask

    task automatic test_priority();
        // Memory data request stalls the fetch
        instr_addr = 32'h40;
        instr_req  = 1'b1;
        data_addr  = 32'h80;
        data_wr_en = 1'b0;
        data_req   = 1'b1;
        @(negedge clk);
        check_ack(1'b1, "data");
        check_ack(1'b0, "instr");
        check_word(data_rd_data, ref_mem[mem_index(32'h80)], "data read under contention");
        data_req = 1'b0;
        @(negedge clk);
        check_ack(1'b1, "instr");
        check_ack(1'b0, "data");
        check_word(instr_data, ref_mem[mem_index(32'h40)], "stalled fetch");
        // System data request runs beside the fetch
        data_addr = sys_addr(5);
        data_req  = 1'b1;
        @(negedge clk);
        check_ack(1'b1, "instr");
        check_ack(1'b1, "data");
        check_word(instr_data, ref_mem[mem_index(32'h40)], "fetch beside system read");
        check_word(data_rd_data, ref_sys[5], "system read beside fetch");
        instr_req = 1'b0;
        data_req  = 1'b0;
        idle_cycle();
    endtask

    task automatic test_system_regs();
        for (int i = 0; i < SYS_WORDS; i++) begin
            data_access(sys_addr(i), 1'b1, word_t'($urandom), mask_t'($urandom), 1'b1);
            check_leds(ref_sys[0][7:0]);
        end
        for (int i = 0; i < SYS_WORDS; i++) begin
            data_access(sys_addr(i), 1'b0, '0, 4'h0, 1'b1);
        end
        data_access(sys_addr(0), 1'b1, 32'h1234_56a5, 4'h1, 1'b1);
        check_leds(8'ha5);
        idle_cycle();
    endtask

    task automatic test_other_region();
        logic [3:0] other;
        addr_t      a;
        other        = SYSTEM_ID + 4'd3;
        a            = 32'h1000 | (addr_t'(other) << 8);
        data_addr    = a;
        data_wr_en   = 1'b1;
        data_wr_data = 32'hffff_ffff;
        data_wr_mask = 4'hf;
        data_req     = 1'b1;
        @(negedge clk);
        check_ack(1'b0, "data");
        data_req   = 1'b0;
        data_wr_en = 1'b0;
        check_leds(ref_sys[0][7:0]);
        // Neither target may have taken the write
        data_access(sys_addr(0), 1'b0, '0, 4'h0, 1'b1);
        data_access(a & ~32'h1000, 1'b0, '0, 4'h0, 1'b1);
        idle_cycle();
    endtask

    task automatic test_random();
        int    kind;
        int    w;
        addr_t hi;
        addr_t a;
        logic  we;
        for (int i = 0; i < 32; i++) begin
            data_access(32'h400 + addr_t'(i * 4), 1'b1, word_t'($urandom), 4'hf, 1'b0);
        end
        for (int n = 0; n < RAND_ACCESSES; n++) begin
            kind = $urandom_range(2, 0);
            hi   = addr_t'($urandom) & 32'hffff_e000;
            we   = 1'($urandom_range(1, 0));
            if (kind == 2) begin
                w = $urandom_range(SYS_WORDS - 1, 0);
                a = hi | sys_addr(w);
                data_access(a, we, word_t'($urandom), mask_t'($urandom), 1'b1);
                check_leds(ref_sys[0][7:0]);
            end
            else begin
                w = $urandom_range(31, 0);
                a = hi | 32'h400 | addr_t'(w << 2);
                if (kind == 0) begin
                    fetch(a);
                end
                else begin
                    data_access(a, we, word_t'($urandom), mask_t'($urandom), 1'b1);
                end
            end
        end
        idle_cycle();
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        void'($urandom(32'h818e));
        rstz         = 1'b0;
        instr_addr   = '0;
        instr_req    = 1'b0;
        data_addr    = '0;
        data_wr_data = '0;
        data_wr_mask = '0;
        data_wr_en   = 1'b0;
        data_req     = 1'b0;
        for (int i = 0; i < SYS_WORDS; i++) begin
            ref_sys[i] = '0;
        end
        repeat (10) @(negedge clk);
        rstz = 1'b1;
        idle_cycle();
        check_leds(8'h00);

        test_full_words();
        test_byte_masks();
        test_priority();
        test_system_regs();
        test_other_region();
        test_random();

        if (uut.u_bus.u_assert.violations == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
